/* list.f */
src/audio_pkg.sv
src/flash_pkg.sv
src/flash_reader.sv
src/sample_fifo.sv
src/playback_rate.sv
src/sample_player.sv
src/simple_ipod.sv
tb/flash_model.sv
tb/tb_simple_ipod.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= tb_simple_ipod
RTL_TOP   ?= simple_ipod
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tb/tb_simple_ipod.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_simple_ipod;
  import audio_pkg::*;
  import flash_pkg::*;

  localparam int LAST_WORD  = 7;
  localparam int FIFO_DEPTH = 8;
  localparam int DIV_DEF    = 24;
  localparam int DIV_STEP   = 4;
  localparam int DIV_MIN    = 16;
  localparam int DIV_MAX    = 40;

  localparam int RATE_UP    = 0;
  localparam int RATE_DOWN  = 1;
  localparam int RATE_RESET = 2;

  // Samples each test waits for with three per rate step
  localparam int T1_SAMPLES      = 40;
  localparam int T2_SAMPLES      = 24;
  localparam int T3_SAMPLES      = 33;
  localparam int T4_SAMPLES      = 12;
  localparam int T5_SAMPLES      = 50;
  localparam int TOTAL_SAMPLES   = T1_SAMPLES + T2_SAMPLES + T3_SAMPLES +
                                   T4_SAMPLES + T5_SAMPLES;
  localparam int WATCHDOG_CYCLES = 2 * TOTAL_SAMPLES * DIV_MAX + 100;
  localparam int PULSE_TIMEOUT   = 16 * DIV_MAX;

  logic              CLK_50M;
  logic              arst_n;
  logic              play;
  logic              reverse;
  logic              restart;
  logic              speed_up;
  logic              speed_down;
  logic              speed_reset;
  logic              stall;
  logic              flash_read;
  flash_addr_t       flash_address;
  logic              flash_waitrequest;
  flash_word_t       flash_readdata;
  logic              flash_readdatavalid;
  logic signed [7:0] audio_sample;
  logic              sample_strobe;
  logic              underrun;
  div_count_t        div_count;

  // Reference model state
  int                exp_addr;
  int                exp_byte;
  logic              exp_rev;
  logic [7:0]        exp_sample;
  logic              model_load;
  logic              load_rev;
  int                exp_div;

  logic              paused;
  logic signed [7:0] held_sample;
  int                cyc;
  int                strobe_cnt;
  int                underrun_cnt;
  int                errors;
  int                tests_run;
  int                tests_failed;

  simple_ipod #(
    .LAST_WORD_ADDR (23'(LAST_WORD)),
    .FIFO_DEPTH     (FIFO_DEPTH),
    .DEFAULT_DIV    (16'(DIV_DEF)),
    .SPEED_STEP     (16'(DIV_STEP)),
    .MIN_DIV        (16'(DIV_MIN)),
    .MAX_DIV        (16'(DIV_MAX))
  ) u_dut (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .play                (play),
    .reverse             (reverse),
    .restart             (restart),
    .speed_up            (speed_up),
    .speed_down          (speed_down),
    .speed_reset         (speed_reset),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid),
    .audio_sample        (audio_sample),
    .sample_strobe       (sample_strobe),
    .underrun            (underrun),
    .div_count           (div_count)
  );

  flash_model #(
    .SEED (52)
  ) u_flash (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .stall               (stall),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdata      (flash_readdata),
    .flash_readdatavalid (flash_readdatavalid)
  );

  initial
  begin
    CLK_50M = 1'b0;
    forever #10 CLK_50M = ~CLK_50M;
  end

  // ========================================
  // Reference model and checks
  // ========================================

  // Flash byte 4a+i+16 less the offset of 128
  function automatic logic [7:0] expected_sample(input int addr, input int idx);
    int raw;
    raw = (4 * addr + idx + 16) % 256;
    return 8'(raw - 128);
  endfunction

  assign exp_sample = expected_sample(exp_addr, exp_byte);

  always @(negedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      exp_addr <= 0;
      exp_byte <= 0;
      exp_rev  <= 1'b0;
    end
    else if (model_load)
    begin
      exp_rev  <= load_rev;
      exp_addr <= load_rev ? LAST_WORD : 0;
      exp_byte <= load_rev ? 3 : 0;
    end
    else if (sample_strobe && exp_rev)
    begin
      exp_byte <= (exp_byte == 0) ? 3 : exp_byte - 1;
      if (exp_byte == 0)
        exp_addr <= (exp_addr == 0) ? LAST_WORD : exp_addr - 1;
    end
    else if (sample_strobe)
    begin
      exp_byte <= (exp_byte == 3) ? 0 : exp_byte + 1;
      if (exp_byte == 3)
        exp_addr <= (exp_addr == LAST_WORD) ? 0 : exp_addr + 1;
    end
  end

  always @(posedge CLK_50M)
    cyc <= cyc + 1;

  always @(negedge CLK_50M)
  begin
    if (sample_strobe)
      strobe_cnt <= strobe_cnt + 1;
    if (underrun)
      underrun_cnt <= underrun_cnt + 1;
  end

  a_sample: assert property (@(negedge CLK_50M) disable iff (!arst_n)
    sample_strobe |-> (audio_sample == exp_sample))
  else
  begin
    errors++;
    $display("error: audio_sample got %h expected %h",
             $sampled(audio_sample), $sampled(exp_sample));
  end

  a_pause: assert property (@(negedge CLK_50M) disable iff (!arst_n)
    paused |-> (!sample_strobe && !underrun && audio_sample == held_sample))
  else
  begin
    errors++;
    $display("error: paused audio_sample %h held %h sample_strobe %h underrun %h",
             $sampled(audio_sample), $sampled(held_sample),
             $sampled(sample_strobe), $sampled(underrun));
  end

  // ========================================
  // Tasks
  // ========================================

  // Returns at the negedge where the pulse is seen
  task automatic wait_for_pulse(input logic on_underrun, output int at_cycle);
    int waited;
    waited = 0;
    do
    begin
      @(negedge CLK_50M);
      waited++;
    end
    while (!(on_underrun ? underrun : sample_strobe) && waited < PULSE_TIMEOUT);
    at_cycle = cyc;
    if (!(on_underrun ? underrun : sample_strobe))
    begin
      errors++;
      $display("%s did not pulse within %0d cycles",
               on_underrun ? "underrun" : "sample_strobe", PULSE_TIMEOUT);
    end
  endtask

  task automatic wait_samples(input int count);
    int t;
    repeat (count)
      wait_for_pulse(1'b0, t);
  endtask

  // Called at a negedge
  task automatic pause_play();
    play        = 1'b0;
    held_sample = audio_sample;
    @(posedge CLK_50M);
    paused = 1'b1;
  endtask

  task automatic resume_play();
    @(posedge CLK_50M);
    paused = 1'b0;
    @(negedge CLK_50M);
    play = 1'b1;
  endtask

  task automatic restart_to(input logic rev);
    @(negedge CLK_50M);
    reverse = rev;
    @(negedge CLK_50M);
    restart = 1'b1;
    @(negedge CLK_50M);
    restart = 1'b0;
    @(posedge CLK_50M);
    load_rev   = rev;
    model_load = 1'b1;
    @(posedge CLK_50M);
    model_load = 1'b0;
  endtask

  task automatic adjust_rate(input int kind);
    int t_prev;
    int t_now;
    case (kind)
      RATE_UP:   speed_up = 1'b1;
      RATE_DOWN: speed_down = 1'b1;
      default:   speed_reset = 1'b1;
    endcase
    @(negedge CLK_50M);
    speed_up    = 1'b0;
    speed_down  = 1'b0;
    speed_reset = 1'b0;
    if (kind == RATE_UP)
      exp_div = (exp_div - DIV_STEP < DIV_MIN) ? DIV_MIN : exp_div - DIV_STEP;
    else if (kind == RATE_DOWN)
      exp_div = (exp_div + DIV_STEP > DIV_MAX) ? DIV_MAX : exp_div + DIV_STEP;
    else
      exp_div = DIV_DEF;
    a_div: assert (div_count == 16'(exp_div))
    else
    begin
      errors++;
      $display("error: div_count got %h expected %h", div_count, 16'(exp_div));
    end
    // Running period still ends on the old divider
    wait_for_pulse(1'b0, t_prev);
    wait_for_pulse(1'b0, t_prev);
    wait_for_pulse(1'b0, t_now);
    a_gap: assert (t_now - t_prev == exp_div)
    else
    begin
      errors++;
      $display("error: sample_strobe spacing got %h expected %h",
               t_now - t_prev, exp_div);
    end
  endtask

  task automatic report_test(input string name, input int errors_before);
    tests_run++;
    if (errors == errors_before)
      $display("test %0d %s: ok", tests_run, name);
    else
    begin
      tests_failed++;
      $display("test %0d %s: failed with %0d errors", tests_run, name,
               errors - errors_before);
    end
  endtask

  // ========================================
  // Stimulus
  // ========================================

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge CLK_50M);
    $display("watchdog expired after %0d cycles, the tests did not finish",
             WATCHDOG_CYCLES);
    $display("STATUS: FAIL");
    $finish;
  end

  initial
  begin
    int e0;
    int t;
    int s0;
    int u0;
    arst_n       = 1'b0;
    play         = 1'b1;
    reverse      = 1'b0;
    restart      = 1'b0;
    speed_up     = 1'b0;
    speed_down   = 1'b0;
    speed_reset  = 1'b0;
    stall        = 1'b0;
    paused       = 1'b0;
    model_load   = 1'b0;
    load_rev     = 1'b0;
    held_sample  = '0;
    exp_div      = DIV_DEF;
    cyc          = 0;
    strobe_cnt   = 0;
    underrun_cnt = 0;
    errors       = 0;
    tests_run    = 0;
    tests_failed = 0;
    repeat (4) @(posedge CLK_50M);
    @(negedge CLK_50M);
    a_reset_div: assert (div_count == 16'(DIV_DEF))
    else
    begin
      errors++;
      $display("error: div_count got %h expected %h", div_count, 16'(DIV_DEF));
    end
    a_reset_out: assert (audio_sample == '0 && !sample_strobe && !underrun && !flash_read)
    else
    begin
      errors++;
      $display("outputs were not idle during reset");
    end
    arst_n = 1'b1;

    // Forward from word 0 and wrapping after word 7
    e0 = errors;
    wait_samples(T1_SAMPLES);
    report_test("forward play", e0);

    e0 = errors;
    pause_play();
    restart_to(1'b1);
    resume_play();
    wait_samples(16);
    pause_play();
    restart_to(1'b0);
    resume_play();
    wait_samples(8);
    report_test("reverse and restart", e0);

    e0 = errors;
    repeat (3) adjust_rate(RATE_UP);
    repeat (7) adjust_rate(RATE_DOWN);
    adjust_rate(RATE_RESET);
    report_test("rate control", e0);

    e0 = errors;
    pause_play();
    repeat (4 * exp_div) @(posedge CLK_50M);
    resume_play();
    wait_samples(8);
    report_test("pause", e0);

    // Random wait-request first and then a stalled flash
    e0 = errors;
    wait_samples(24);
    stall = 1'b1;
    wait_for_pulse(1'b1, t);
    @(posedge CLK_50M);
    s0 = strobe_cnt;
    u0 = underrun_cnt;
    repeat (5 * exp_div) @(posedge CLK_50M);
    a_underrun: assert (underrun_cnt - u0 == 5)
    else
    begin
      errors++;
      $display("error: underrun count got %h expected %h", underrun_cnt - u0, 5);
    end
    a_no_strobe: assert (strobe_cnt == s0)
    else
    begin
      errors++;
      $display("sample_strobe pulsed while the flash was stalled and the FIFO empty");
    end
    @(negedge CLK_50M);
    stall = 1'b0;
    wait_samples(8);
    report_test("back-pressure and underrun", e0);

    $display("tests run %0d, tests failed %0d, errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0)
      $display("STATUS: PASS");
    else
      $display("STATUS: FAIL");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/flash_model.sv */
`timescale 1ns/10ps
`default_nettype none

module flash_model #(
  parameter int unsigned SEED = 52
) (
  input  logic                   CLK_50M,
  input  logic                   arst_n,
  input  logic                   stall,
  input  logic                   flash_read,
  input  flash_pkg::flash_addr_t flash_address,
  output logic                   flash_waitrequest,
  output flash_pkg::flash_word_t flash_readdata,
  output logic                   flash_readdatavalid
);
  import flash_pkg::*;

  logic [31:0] rng;
  logic        pending;
  flash_addr_t addr_q;
  logic [2:0]  latency;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Byte i of word a is the low byte of 4a+i+16
  function automatic flash_word_t word_at(input flash_addr_t a);
    flash_word_t w;
    for (int i = 0; i < BYTES_PER_WORD; i++)
      w[8*i +: 8] = 8'(4 * int'(a) + i + 16);
    return w;
  endfunction

  always @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      rng                 <= SEED;
      flash_waitrequest   <= 1'b0;
      flash_readdatavalid <= 1'b0;
      flash_readdata      <= '0;
      pending             <= 1'b0;
      addr_q              <= '0;
      latency             <= '0;
    end
    else
    begin
      rng                 <= xorshift(rng);
      // Busy about a quarter of the time, always busy while stalled
      flash_waitrequest   <= stall || (rng[5:4] == 2'b00);
      flash_readdatavalid <= 1'b0;
      if (pending)
      begin
        if (latency <= 3'd1)
        begin
          flash_readdatavalid <= 1'b1;
          flash_readdata      <= word_at(addr_q);
          pending             <= 1'b0;
        end
        else
          latency <= latency - 3'd1;
      end
      else if (flash_read && !flash_waitrequest)
      begin
        pending <= 1'b1;
        addr_q  <= flash_address;
        // 1 to 4 cycles until the data
        latency <= 3'd1 + {1'b0, rng[1:0]};
      end
    end
  end

endmodule

`default_nettype wire

/* src/simple_ipod.sv */
`timescale 1ns/10ps
`default_nettype none

module simple_ipod #(
  parameter flash_pkg::flash_addr_t LAST_WORD_ADDR = 23'h7FFFF,
  parameter int                     FIFO_DEPTH     = 16,
  parameter audio_pkg::div_count_t  DEFAULT_DIV    = audio_pkg::DEFAULT_DIV_COUNT,
  parameter audio_pkg::div_count_t  SPEED_STEP     = audio_pkg::DEFAULT_SPEED_STEP,
  parameter audio_pkg::div_count_t  MIN_DIV        = audio_pkg::DEFAULT_MIN_DIV,
  parameter audio_pkg::div_count_t  MAX_DIV        = audio_pkg::DEFAULT_MAX_DIV
) (
  input  logic                   CLK_50M,
  input  logic                   arst_n,
  // Player controls
  input  logic                   play,
  input  logic                   reverse,
  input  logic                   restart,
  input  logic                   speed_up,
  input  logic                   speed_down,
  input  logic                   speed_reset,
  // Flash read bus
  output logic                   flash_read,
  output flash_pkg::flash_addr_t flash_address,
  input  logic                   flash_waitrequest,
  input  flash_pkg::flash_word_t flash_readdata,
  input  logic                   flash_readdatavalid,
  // Audio out
  output logic signed [7:0]      audio_sample,
  output logic                   sample_strobe,
  output logic                   underrun,
  output audio_pkg::div_count_t  div_count
);
  import audio_pkg::*;

  logic                            push;
  sample_t                         push_data;
  logic [$clog2(FIFO_DEPTH+1)-1:0] free_count;
  logic                            pop;
  sample_t                         pop_data;
  logic                            fifo_empty;
  logic                            tick;

  // ========================================
  // Producer and buffer
  // ========================================

  flash_reader #(
    .LAST_WORD_ADDR (LAST_WORD_ADDR),
    .FIFO_DEPTH     (FIFO_DEPTH)
  ) u_flash_reader (
    .CLK_50M             (CLK_50M),
    .arst_n              (arst_n),
    .play                (play),
    .reverse             (reverse),
    .restart             (restart),
    .flash_waitrequest   (flash_waitrequest),
    .flash_readdatavalid (flash_readdatavalid),
    .flash_readdata      (flash_readdata),
    .free_count          (free_count),
    .flash_read          (flash_read),
    .flash_address       (flash_address),
    .push                (push),
    .push_data           (push_data)
  );

  // Restart also empties the buffer
  sample_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_sample_fifo (
    .CLK_50M    (CLK_50M),
    .arst_n     (arst_n),
    .push       (push),
    .push_data  (push_data),
    .pop        (pop),
    .flush      (restart),
    .pop_data   (pop_data),
    .empty      (fifo_empty),
    .free_count (free_count)
  );

  // ========================================
  // Rate and consumer
  // ========================================

  playback_rate #(
    .DEFAULT_DIV (DEFAULT_DIV),
    .SPEED_STEP  (SPEED_STEP),
    .MIN_DIV     (MIN_DIV),
    .MAX_DIV     (MAX_DIV)
  ) u_playback_rate (
    .CLK_50M     (CLK_50M),
    .arst_n      (arst_n),
    .speed_up    (speed_up),
    .speed_down  (speed_down),
    .speed_reset (speed_reset),
    .div_count   (div_count),
    .tick        (tick)
  );

  sample_player u_sample_player (
    .CLK_50M       (CLK_50M),
    .arst_n        (arst_n),
    .tick          (tick),
    .play          (play),
    .pop_data      (pop_data),
    .empty         (fifo_empty),
    .pop           (pop),
    .audio_sample  (audio_sample),
    .sample_strobe (sample_strobe),
    .underrun      (underrun)
  );

endmodule

`default_nettype wire

/* src/sample_player.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_player (
  input  logic               CLK_50M,
  input  logic               arst_n,
  input  logic               tick,
  input  logic               play,
  input  audio_pkg::sample_t pop_data,
  input  logic               empty,
  output logic               pop,
  output audio_pkg::sample_t audio_sample,
  output logic               sample_strobe,
  output logic               underrun
);

  logic want_sample;

  // One sample per tick while playing
  assign want_sample = tick && play;
  assign pop         = want_sample && !empty;

  // ========================================
  // Output registers
  // ========================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      audio_sample  <= '0;
      sample_strobe <= 1'b0;
      underrun      <= 1'b0;
    end
    else
    begin
      sample_strobe <= pop;

      // Tick came but the buffer ran dry
      underrun      <= want_sample && empty;

      // Offset binary to two's complement, flip the MSB
      if (pop)
        audio_sample <= {~pop_data[7], pop_data[6:0]};
    end
  end

endmodule

`default_nettype wire

/* src/playback_rate.sv */
`timescale 1ns/10ps
`default_nettype none

module playback_rate #(
  parameter audio_pkg::div_count_t DEFAULT_DIV = audio_pkg::DEFAULT_DIV_COUNT,
  parameter audio_pkg::div_count_t SPEED_STEP  = audio_pkg::DEFAULT_SPEED_STEP,
  parameter audio_pkg::div_count_t MIN_DIV     = audio_pkg::DEFAULT_MIN_DIV,
  parameter audio_pkg::div_count_t MAX_DIV     = audio_pkg::DEFAULT_MAX_DIV
) (
  input  logic                  CLK_50M,
  input  logic                  arst_n,
  input  logic                  speed_up,
  input  logic                  speed_down,
  input  logic                  speed_reset,
  output audio_pkg::div_count_t div_count,
  output logic                  tick
);
  import audio_pkg::*;

  div_count_t  tick_cnt;
  div_count_t  period_div;
  logic        period_end;
  logic [16:0] div_minus;   // bit 16 set on underflow
  logic [16:0] div_plus;

  assign div_minus = {1'b0, div_count} - {1'b0, SPEED_STEP};
  assign div_plus  = {1'b0, div_count} + {1'b0, SPEED_STEP};

  // ========================================
  // Divider register
  // ========================================

  // Smaller divider means faster playback
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
      div_count <= DEFAULT_DIV;
    else if (speed_reset)
      div_count <= DEFAULT_DIV;
    else if (speed_up)
    begin
      if (div_minus[16] || (div_minus < {1'b0, MIN_DIV}))
        div_count <= MIN_DIV;
      else
        div_count <= div_minus[15:0];
    end
    else if (speed_down)
    begin
      if (div_plus > {1'b0, MAX_DIV})
        div_count <= MAX_DIV;
      else
        div_count <= div_plus[15:0];
    end
  end

  // ========================================
  // Tick counter
  // ========================================

  // Divider in use for the running period
  assign period_end = (tick_cnt == period_div - 16'd1);

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      tick_cnt   <= '0;
      period_div <= DEFAULT_DIV;
      tick       <= 1'b0;
    end
    else
    begin
      tick <= period_end;
      if (period_end)
      begin
        tick_cnt   <= '0;
        // New divider starts with the next period
        period_div <= div_count;
      end
      else
        tick_cnt <= tick_cnt + 1'b1;
    end
  end

endmodule

`default_nettype wire

/* src/sample_fifo.sv */
`timescale 1ns/10ps
`default_nettype none

module sample_fifo #(
  parameter int FIFO_DEPTH = 16
) (
  input  logic                            CLK_50M,
  input  logic                            arst_n,
  input  logic                            push,
  input  audio_pkg::sample_t              push_data,
  input  logic                            pop,
  input  logic                            flush,
  output audio_pkg::sample_t              pop_data,
  output logic                            empty,
  output logic [$clog2(FIFO_DEPTH+1)-1:0] free_count
);
  import audio_pkg::*;

  localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

  sample_t          mem [FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             full;
  logic             do_push;
  logic             do_pop;

  // Pointer step with wrap, depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    return (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign empty      = (count == '0);
  assign full       = (count == CNT_W'(FIFO_DEPTH));
  assign free_count = CNT_W'(FIFO_DEPTH) - count;
  assign do_push    = push && !full;
  assign do_pop     = pop && !empty;

  // Head entry, removed at the edge of a pop
  assign pop_data   = mem[rd_ptr];

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else if (flush)
    begin
      // Flush wins over a push in the same cycle
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end
    else
    begin
      if (do_push)
        wr_ptr <= ptr_inc(wr_ptr);
      if (do_pop)
        rd_ptr <= ptr_inc(rd_ptr);
      case ({do_push, do_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge CLK_50M)
  begin
    if (do_push)
      mem[wr_ptr] <= push_data;
  end

endmodule

`default_nettype wire

/* src/flash_reader.sv */
`timescale 1ns/10ps
`default_nettype none

module flash_reader #(
  parameter flash_pkg::flash_addr_t LAST_WORD_ADDR = 23'h7FFFF,
  parameter int                     FIFO_DEPTH     = 16
) (
  input  logic                              CLK_50M,
  input  logic                              arst_n,
  input  logic                              play,
  input  logic                              reverse,
  input  logic                              restart,
  input  logic                              flash_waitrequest,
  input  logic                              flash_readdatavalid,
  input  flash_pkg::flash_word_t            flash_readdata,
  input  logic [$clog2(FIFO_DEPTH+1)-1:0]   free_count,
  output logic                              flash_read,
  output flash_pkg::flash_addr_t            flash_address,
  output logic                              push,
  output audio_pkg::sample_t                push_data
);
  import flash_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_READ,
    ST_WAIT,
    ST_PUSH
  } state_t;

  state_t      state;
  flash_addr_t next_addr;
  flash_word_t word_q;
  logic        dir_q;
  byte_sel_t   byte_idx;
  logic        discard;
  logic        start_read;
  logic        last_byte;

  // Room for a whole word must be free before a fetch
  assign start_read = (state == ST_IDLE) && play && !restart &&
                      (free_count >= BYTES_PER_WORD);

  assign last_byte  = dir_q ? (byte_idx == 2'd0) : (byte_idx == 2'd3);

  assign flash_read = (state == ST_READ);
  assign push       = (state == ST_PUSH);
  assign push_data  = word_q[{byte_idx, 3'b000} +: 8];

  // ========================================
  // Word address sequencing
  // ========================================

  // flash_address only changes when a new read is issued,
  // so it stays put until the flash accepts the request
  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      next_addr     <= '0;
      flash_address <= '0;
    end
    else if (restart)
    begin
      next_addr <= reverse ? LAST_WORD_ADDR : '0;
    end
    else if (start_read)
    begin
      flash_address <= next_addr;
      if (reverse)
        next_addr <= (next_addr == '0) ? LAST_WORD_ADDR : next_addr - 1'b1;
      else
        next_addr <= (next_addr == LAST_WORD_ADDR) ? '0 : next_addr + 1'b1;
    end
  end

  // ========================================
  // Read and push FSM
  // ========================================

  always_ff @(posedge CLK_50M or negedge arst_n)
  begin
    if (!arst_n)
    begin
      state    <= ST_IDLE;
      discard  <= 1'b0;
      dir_q    <= 1'b0;
      byte_idx <= '0;
    end
    else
    begin
      case (state)
        ST_IDLE:
        begin
          if (start_read)
            state <= ST_READ;
        end
        ST_READ:
        begin
          // Request already on the bus, let it finish and drop the data
          if (restart)
            discard <= 1'b1;
          if (!flash_waitrequest)
            state <= ST_WAIT;
        end
        ST_WAIT:
        begin
          if (flash_readdatavalid)
          begin
            discard <= 1'b0;
            if (discard || restart)
              state <= ST_IDLE;
            else
            begin
              state    <= ST_PUSH;
              dir_q    <= reverse;
              byte_idx <= reverse ? 2'd3 : 2'd0;
            end
          end
          else if (restart)
            discard <= 1'b1;
        end
        ST_PUSH:
        begin
          // FIFO is flushed on restart, remaining bytes are stale
          if (restart || last_byte)
            state <= ST_IDLE;
          else if (dir_q)
            byte_idx <= byte_idx - 1'b1;
          else
            byte_idx <= byte_idx + 1'b1;
        end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Word held for the four pushes
  always_ff @(posedge CLK_50M)
  begin
    if ((state == ST_WAIT) && flash_readdatavalid)
      word_q <= flash_readdata;
  end

endmodule

`default_nettype wire

/* src/flash_pkg.sv */
`default_nettype none

package flash_pkg;

  // ========================================
  // Flash read bus
  // ========================================

  // Word address, one 32-bit word per address
  typedef logic [22:0] flash_addr_t;

  // Read data from the flash
  typedef logic [31:0] flash_word_t;

  // Byte lanes in one word
  localparam int BYTES_PER_WORD = 4;

  // Index of a byte lane, byte 0 in bits 7:0
  typedef logic [1:0] byte_sel_t;

endpackage

`default_nettype wire

/* src/audio_pkg.sv */
`default_nettype none

package audio_pkg;

  // ========================================
  // Sample and rate types
  // ========================================

  // One audio sample, offset binary as stored in flash
  typedef logic [7:0] sample_t;

  // Playback tick divider, in CLK_50M cycles
  typedef logic [15:0] div_count_t;

  // ========================================
  // Rate defaults
  // ========================================

  // About 44 kHz from 50 MHz
  localparam div_count_t DEFAULT_DIV_COUNT  = 16'd1136;
  localparam div_count_t DEFAULT_SPEED_STEP = 16'd100;

  // Half and double the default rate
  localparam div_count_t DEFAULT_MIN_DIV    = 16'd568;
  localparam div_count_t DEFAULT_MAX_DIV    = 16'd2272;

endpackage

`default_nettype wire
